// File: build.f
spi_pkg.sv
spi_regs.sv
spi_engine.sv
spi_controller.sv
spi_target_model.sv
tb_spi_controller.sv

// File: Makefile
TOP = tb_spi_controller

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f build.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -Mdir obj_dir -f build.f
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "RESULT: PASS"

clean:
	rm -rf obj_dir

// File: tb_spi_controller.sv
// ----------------------------
// SPI controller testbench
// Directed bus tests against an
// echoing SPI target on cs[1]
// ----------------------------

`timescale 1ns/1ps
`default_nettype none

module tb_spi_controller;

  localparam int num_chip_select = 4;
  localparam int reset_cycles    = 16;
  localparam int max_div         = 3;
  localparam int transfer_count  = 10;
  localparam int transfer_cycles = 16 * (max_div + 1) + 40;
  localparam int watchdog_cycles = 2 * (reset_cycles + 300 + transfer_count * transfer_cycles);

  logic        clock;
  logic        reset;
  logic [4:0]  rw_address;
  logic        read_request;
  logic        read_response;
  logic [31:0] read_data;
  logic        write_request;
  logic        write_response;
  logic [7:0]  write_data;
  logic [3:0]  write_strobe;
  logic        sclk;
  logic        pico;
  logic        poci;
  logic [num_chip_select-1:0] cs;

  logic       mode_cpol;
  logic       mode_cpha;
  logic       check_rest;
  logic       busy_last;
  logic [7:0] target_rx;
  logic [7:0] expected_reply;
  int         target_count;
  int         busy_total;
  int         rest_errors;
  int         error_count;
  int         seed;

  spi_controller #(.num_chip_select(num_chip_select)) dut_i (.*);

  spi_target_model target_i (
    .sclk     (sclk),
    .pico     (pico),
    .poci     (poci),
    .cs_n     (cs[1]),
    .cpol     (mode_cpol),
    .cpha     (mode_cpha),
    .last_rx  (target_rx),
    .rx_count (target_count)
  );

  always #50 clock = ~clock;

  // Busy cycles and sclk rest level, sampled mid-cycle
  initial begin
    busy_total  = 0;
    rest_errors = 0;
    busy_last   = 1'b0;
    forever begin
      @(negedge clock);
      if (dut_i.engine_i.busy) begin
        busy_total = busy_total + 1;
      end
      if (check_rest && !dut_i.engine_i.busy && !busy_last && sclk !== mode_cpol) begin
        $display("Error: sclk left its rest level while the engine was idle");
        rest_errors = rest_errors + 1;
      end
      busy_last = dut_i.engine_i.busy;
    end
  end

  function automatic int total_errors();
    return error_count + rest_errors;
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
    $display("Error: %s expected %h actual %h", name, expected, actual);
    error_count = error_count + 1;
  endtask

  task automatic report_failure(input string text);
    $display("Error: %s", text);
    error_count = error_count + 1;
  endtask

  task automatic finish_test(input string name, input int start);
    $display("Test %s finished with %0d errors", name, total_errors() - start);
  endtask

  task automatic step_cycle();
    @(posedge clock);
    #1;
  endtask

  // ----------------------------
  // Bus access
  // ----------------------------
  task automatic bus_write(input logic [4:0] address, input logic [7:0] data,
                           input logic [3:0] strobe);
    rw_address    = address;
    write_data    = data;
    write_strobe  = strobe;
    write_request = 1'b1;
    step_cycle();
    write_request = 1'b0;
    if (write_response !== 1'b1) begin
      report_failure("no write response one cycle after the request");
    end
  endtask

  task automatic bus_read(input logic [4:0] address, output logic [31:0] data);
    rw_address   = address;
    read_request = 1'b1;
    step_cycle();
    read_request = 1'b0;
    if (read_response !== 1'b1) begin
      report_failure("no read response one cycle after the request");
    end
    data = read_data;
  endtask

  task automatic check_read(input string name, input logic [4:0] address,
                            input logic [31:0] expected);
    logic [31:0] value;
    bus_read(address, value);
    if (value !== expected) begin
      report_mismatch(name, expected, value);
    end
  endtask

  // Start state lags tx_start, so skip a cycle before polling
  task automatic wait_idle();
    logic [31:0] value;
    int polls;
    step_cycle();
    polls = 0;
    value = 32'd1;
    while (value !== 32'd0 && polls < transfer_cycles) begin
      bus_read(spi_pkg::reg_busy, value);
      polls++;
    end
    if (value !== 32'd0) begin
      report_failure("busy still set after the poll limit");
    end
  endtask

  // Deselect first so the target sees no stray sclk edge
  task automatic configure(input logic cpol, input logic cpha, input logic [7:0] div);
    bus_write(spi_pkg::reg_chip_select, spi_pkg::cs_none, 4'hf);
    mode_cpol = cpol;
    mode_cpha = cpha;
    bus_write(spi_pkg::reg_cpol, {7'd0, cpol}, 4'hf);
    bus_write(spi_pkg::reg_cpha, {7'd0, cpha}, 4'hf);
    bus_write(spi_pkg::reg_clock_conf, div, 4'hf);
    bus_write(spi_pkg::reg_chip_select, 8'd1, 4'hf);
  endtask

  task automatic exchange(input logic [7:0] tx, input string name);
    logic [31:0] value;
    int count;
    count = target_count;
    bus_write(spi_pkg::reg_wdata, tx, 4'hf);
    wait_idle();
    bus_read(spi_pkg::reg_rdata, value);
    if (target_count != count + 1) report_failure({name, ": target missed the transfer"});
    if (target_rx !== tx) report_mismatch({name, " target byte"}, 32'(tx), 32'(target_rx));
    if (value !== 32'(expected_reply)) begin
      report_mismatch({name, " rdata"}, 32'(expected_reply), value);
    end
    expected_reply = tx ^ 8'ha5;
  endtask

  // ----------------------------
  // Tests
  // ----------------------------
  task automatic test_reset_readback();
    int start;
    start = total_errors();
    if (cs !== 4'hf) report_mismatch("reset cs", 32'hf, 32'(cs));
    if (sclk !== 1'b0) report_mismatch("reset sclk", 32'd0, 32'(sclk));
    if (pico !== 1'b0) report_mismatch("reset pico", 32'd0, 32'(pico));
    if (read_response !== 1'b0 || write_response !== 1'b0) begin
      report_failure("a bus response was high after reset with no request");
    end
    check_read("reset cpol", spi_pkg::reg_cpol, 32'd0);
    check_read("reset cpha", spi_pkg::reg_cpha, 32'd0);
    check_read("reset chip_select", spi_pkg::reg_chip_select, 32'(spi_pkg::cs_none));
    check_read("reset clock_div", spi_pkg::reg_clock_conf, 32'd0);
    check_read("reset rdata", spi_pkg::reg_rdata, 32'd0);
    check_read("reset busy", spi_pkg::reg_busy, 32'd0);
    bus_write(spi_pkg::reg_cpol, 8'd1, 4'hf);
    bus_write(spi_pkg::reg_cpha, 8'd1, 4'hf);
    bus_write(spi_pkg::reg_chip_select, 8'd2, 4'hf);
    bus_write(spi_pkg::reg_clock_conf, 8'h5a, 4'hf);
    check_read("cpol readback", spi_pkg::reg_cpol, 32'd1);
    check_read("cpha readback", spi_pkg::reg_cpha, 32'd1);
    check_read("chip_select readback", spi_pkg::reg_chip_select, 32'd2);
    check_read("clock_div readback", spi_pkg::reg_clock_conf, 32'h5a);
    check_read("unmapped address", 5'h1c, spi_pkg::read_default);
    bus_write(spi_pkg::reg_clock_conf, 8'h33, 4'b0111);
    check_read("partial strobe", spi_pkg::reg_clock_conf, 32'h5a);
    configure(1'b0, 1'b0, 8'd0);
    bus_write(spi_pkg::reg_chip_select, spi_pkg::cs_none, 4'hf);
    finish_test("reset_readback", start);
  endtask

  task automatic test_mode0_transfer();
    int start;
    int busy_start;
    start = total_errors();
    configure(1'b0, 1'b0, 8'd2);
    busy_start = busy_total;
    exchange(8'h96, "mode0");
    if (busy_total - busy_start != 16 * 3) begin
      report_mismatch("mode0 busy cycles", 32'd48, 32'(busy_total - busy_start));
    end
    finish_test("mode0_transfer", start);
  endtask

  task automatic test_four_modes();
    int start;
    int mode;
    start = total_errors();
    for (mode = 0; mode < 4; mode++) begin
      check_rest = 1'b0;
      configure(mode[1], mode[0], 8'(mode));
      check_rest = 1'b1;
      exchange(8'($random(seed)), $sformatf("mode %0d", mode));
    end
    check_rest = 1'b0;
    finish_test("four_modes", start);
  endtask

  task automatic test_chip_select();
    logic [7:0] reply;
    int start;
    int busy_start;
    int count;
    start = total_errors();
    configure(1'b0, 1'b0, 8'd1);
    reply = expected_reply;
    bus_write(spi_pkg::reg_wdata, 8'h5e, 4'hf);
    repeat (4) step_cycle();
    if (cs !== 4'b1101) report_mismatch("cs while selected", 32'hd, 32'(cs));
    wait_idle();
    if (target_rx !== 8'h5e) report_mismatch("select 1 target byte", 32'h5e, 32'(target_rx));
    check_read("rdata with select 1", spi_pkg::reg_rdata, 32'(reply));
    expected_reply = 8'h5e ^ 8'ha5;
    // No device selected
    bus_write(spi_pkg::reg_chip_select, spi_pkg::cs_none, 4'hf);
    busy_start = busy_total;
    bus_write(spi_pkg::reg_wdata, 8'h11, 4'hf);
    repeat (40) step_cycle();
    if (cs !== 4'hf) report_mismatch("cs with cs_none", 32'hf, 32'(cs));
    if (busy_total != busy_start) report_failure("busy rose with no device selected");
    check_read("rdata with cs_none", spi_pkg::reg_rdata, 32'(reply));
    // Select beyond the last pin
    bus_write(spi_pkg::reg_chip_select, 8'd6, 4'hf);
    busy_start = busy_total;
    count = target_count;
    bus_write(spi_pkg::reg_wdata, 8'h22, 4'hf);
    repeat (4) step_cycle();
    if (cs !== 4'hf) report_mismatch("cs with select 6", 32'hf, 32'(cs));
    wait_idle();
    if (busy_total - busy_start != 16 * 2) begin
      report_mismatch("busy cycles with select 6", 32'd32, 32'(busy_total - busy_start));
    end
    if (target_count != count) report_failure("target saw a transfer with select 6");
    finish_test("chip_select", start);
  endtask

  task automatic test_write_while_busy();
    logic [31:0] value;
    int start;
    int busy_start;
    int count;
    start = total_errors();
    configure(1'b0, 1'b0, 8'd2);
    count = target_count;
    busy_start = busy_total;
    bus_write(spi_pkg::reg_wdata, 8'hc3, 4'hf);
    bus_write(spi_pkg::reg_wdata, 8'h3a, 4'hf);
    repeat (4) step_cycle();
    bus_write(spi_pkg::reg_wdata, 8'h3a, 4'hf);
    wait_idle();
    bus_read(spi_pkg::reg_rdata, value);
    if (target_count != count + 1) report_failure("target did not see exactly one transfer");
    if (target_rx !== 8'hc3) report_mismatch("busy write target byte", 32'hc3, 32'(target_rx));
    if (value !== 32'(expected_reply)) begin
      report_mismatch("busy write rdata", 32'(expected_reply), value);
    end
    if (busy_total - busy_start != 16 * 3) begin
      report_mismatch("busy write busy cycles", 32'd48, 32'(busy_total - busy_start));
    end
    expected_reply = 8'hc3 ^ 8'ha5;
    finish_test("write_while_busy", start);
  endtask

  initial begin
    clock          = 1'b0;
    reset          = 1'b1;
    rw_address     = 5'd0;
    read_request   = 1'b0;
    write_request  = 1'b0;
    write_data     = 8'd0;
    write_strobe   = 4'd0;
    mode_cpol      = 1'b0;
    mode_cpha      = 1'b0;
    check_rest     = 1'b0;
    expected_reply = 8'h3c;
    error_count    = 0;
    seed           = 32'hf9f9;
    repeat (reset_cycles) @(posedge clock);
    #1;
    reset = 1'b0;
    test_reset_readback();
    test_mode0_transfer();
    test_four_modes();
    test_chip_select();
    test_write_while_busy();
    $display("Tests run: 5, errors: %0d", total_errors());
    if (total_errors() == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  initial begin
    repeat (watchdog_cycles) @(posedge clock);
    $display("Error: watchdog expired before the tests finished");
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// File: spi_target_model.sv
// ----------------------------
// SPI target model
// Records each byte it receives and
// sends it back XOR 0xa5 next time
// ----------------------------

`timescale 1ns/1ps
`default_nettype none

module spi_target_model (
  input  logic       sclk,
  input  logic       pico,
  output logic       poci,
  input  logic       cs_n,
  input  logic       cpol,
  input  logic       cpha,
  output logic [7:0] last_rx,
  output int         rx_count
);

  logic [7:0] out_reg;
  logic [7:0] in_reg;
  logic [7:0] rx_byte;
  logic       sclk_last;
  int         bit_count;
  int         byte_count;

  assign poci     = out_reg[7];
  assign last_rx  = rx_byte;
  assign rx_count = byte_count;

  initial begin
    out_reg    = 8'h3c;
    in_reg     = 8'h00;
    rx_byte    = 8'h00;
    sclk_last  = 1'b0;
    bit_count  = 0;
    byte_count = 0;
    forever begin
      @(sclk or cs_n);
      if (cs_n !== 1'b0) begin
        bit_count = 0;
      end else if (sclk !== sclk_last) begin
        // Leading edge leaves the rest level
        if (sclk !== cpol) begin
          if (!cpha) begin
            in_reg = {in_reg[6:0], pico};
          end else if (bit_count != 0) begin
            out_reg = {out_reg[6:0], 1'b0};
          end
        end else begin
          if (cpha) begin
            in_reg = {in_reg[6:0], pico};
          end
          bit_count++;
          if (bit_count == 8) begin
            rx_byte    = in_reg;
            out_reg    = in_reg ^ 8'ha5;
            byte_count = byte_count + 1;
            bit_count  = 0;
          end else if (!cpha) begin
            out_reg = {out_reg[6:0], 1'b0};
          end
        end
      end
      sclk_last = sclk;
    end
  end

endmodule

`default_nettype wire

// File: spi_controller.sv
// ----------------------------
// SPI controller top level
// Register file plus transfer
// engine behind a simple bus
// ----------------------------

`timescale 1ns/1ps
`default_nettype none

module spi_controller #(
  parameter int num_chip_select = 4
) (
  input  logic                       clock,
  input  logic                       reset,

  // Bus
  input  logic [4:0]                 rw_address,
  input  logic                       read_request,
  output logic                       read_response,
  output logic [31:0]                read_data,
  input  logic                       write_request,
  output logic                       write_response,
  input  logic [7:0]                 write_data,
  input  logic [3:0]                 write_strobe,

  // SPI pins
  output logic                       sclk,
  output logic                       pico,
  input  logic                       poci,
  output logic [num_chip_select-1:0] cs
);

  logic       cpol;
  logic       cpha;
  logic [7:0] chip_select;
  logic [7:0] clock_div;
  logic [7:0] tx_data;
  logic       tx_start;
  logic       busy;
  logic [7:0] rx_data;

  spi_regs regs_i (
    .clock          (clock),
    .reset          (reset),
    .rw_address     (rw_address),
    .read_request   (read_request),
    .read_data      (read_data),
    .read_response  (read_response),
    .write_data     (write_data),
    .write_strobe   (write_strobe),
    .write_request  (write_request),
    .write_response (write_response),
    .busy           (busy),
    .rx_data        (rx_data),
    .cpol           (cpol),
    .cpha           (cpha),
    .chip_select    (chip_select),
    .clock_div      (clock_div),
    .tx_data        (tx_data),
    .tx_start       (tx_start)
  );

  spi_engine #(
    .num_chip_select (num_chip_select)
  ) engine_i (
    .clock       (clock),
    .reset       (reset),
    .cpol        (cpol),
    .cpha        (cpha),
    .chip_select (chip_select),
    .clock_div   (clock_div),
    .tx_data     (tx_data),
    .tx_start    (tx_start),
    .busy        (busy),
    .rx_data     (rx_data),
    .sclk        (sclk),
    .pico        (pico),
    .poci        (poci),
    .cs          (cs)
  );

endmodule

`default_nettype wire

// File: spi_engine.sv
// ----------------------------
// SPI transfer engine
// One byte per transfer, MSB first,
// any cpol/cpha mode, registered pins
// ----------------------------

`timescale 1ns/1ps
`default_nettype none

module spi_engine #(
  parameter int num_chip_select = 4
) (
  input  logic                       clock,
  input  logic                       reset,

  // Configuration and control
  input  logic                       cpol,
  input  logic                       cpha,
  input  logic [7:0]                 chip_select,
  input  logic [7:0]                 clock_div,
  input  logic [7:0]                 tx_data,
  input  logic                       tx_start,
  output logic                       busy,
  output logic [7:0]                 rx_data,

  // Pins
  output logic                       sclk,
  output logic                       pico,
  input  logic                       poci,
  output logic [num_chip_select-1:0] cs
);

  spi_pkg::spi_state_t state;
  spi_pkg::spi_state_t state_next;
  spi_pkg::spi_state_t start_state;

  logic [7:0] cycle_count;
  logic [2:0] bit_count;
  logic [7:0] tx_shift;
  logic [7:0] rx_shift;
  logic [7:0] rx_next;
  logic       half_end;
  logic       bit_end;
  logic       sample;
  logic       start;
  logic       finish;
  logic       sclk_next;
  logic       pico_next;
  logic [num_chip_select-1:0] cs_next;

  assign busy = (state == spi_pkg::st_phase_a) || (state == spi_pkg::st_phase_n);

  assign start       = tx_start && !busy;
  assign start_state = cpha ? spi_pkg::st_phase_n : spi_pkg::st_phase_a;
  assign half_end    = busy && (cycle_count == clock_div);

  // A bit ends on the trailing half of its sclk period
  assign bit_end = half_end &&
                   ((!cpha && state == spi_pkg::st_phase_n) ||
                    (cpha && state == spi_pkg::st_phase_a));
  assign finish  = bit_end && (bit_count == 3'd0);

  // Sample with the pin edge, which trails the state change by a cycle
  assign sample = busy && (cycle_count == 8'd0) &&
                  ((!cpha && state == spi_pkg::st_phase_n) ||
                   (cpha && state == spi_pkg::st_phase_a));
  assign rx_next = sample ? {rx_shift[6:0], poci} : rx_shift;

  // ----------------------------
  // State machine
  // ----------------------------
  always_comb begin
    state_next = state;
    unique case (state)
      spi_pkg::st_ready,
      spi_pkg::st_idle: begin
        if (tx_start) begin
          state_next = start_state;
        end
      end
      spi_pkg::st_phase_a: begin
        if (half_end) begin
          state_next = finish ? spi_pkg::st_idle : spi_pkg::st_phase_n;
        end
      end
      spi_pkg::st_phase_n: begin
        if (half_end) begin
          state_next = finish ? spi_pkg::st_idle : spi_pkg::st_phase_a;
        end
      end
      default: state_next = spi_pkg::st_ready;
    endcase
  end

  // Deselecting forces the rest state
  always_ff @(posedge clock) begin
    if (reset || chip_select == spi_pkg::cs_none) begin
      state <= spi_pkg::st_ready;
    end else begin
      state <= state_next;
    end
  end

  // ----------------------------
  // Counters
  // ----------------------------
  always_ff @(posedge clock) begin
    if (reset) begin
      cycle_count <= 8'd0;
      bit_count   <= 3'd7;
    end else begin
      if (!busy || half_end) begin
        cycle_count <= 8'd0;
      end else begin
        cycle_count <= cycle_count + 8'd1;
      end
      if (start) begin
        bit_count <= 3'd7;
      end else if (bit_end) begin
        bit_count <= bit_count - 3'd1;
      end
    end
  end

  // ----------------------------
  // Shift registers
  // ----------------------------
  always_ff @(posedge clock) begin
    if (start) begin
      tx_shift <= tx_data;
    end else if (bit_end) begin
      tx_shift <= {tx_shift[6:0], 1'b0};
    end
    rx_shift <= rx_next;
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      rx_data <= 8'h00;
    end else if (finish) begin
      rx_data <= rx_next;
    end
  end

  // ----------------------------
  // Pins
  // ----------------------------
  assign sclk_next = (state == spi_pkg::st_phase_n) ? !cpol : cpol;
  assign pico_next = busy ? tx_shift[7] : 1'b0;

  // Out-of-range selects drive no pin
  always_comb begin
    for (int n = 0; n < num_chip_select; n++) begin
      cs_next[n] = (chip_select != 8'(n));
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      sclk <= 1'b0;
      pico <= 1'b0;
      cs   <= '1;
    end else begin
      sclk <= sclk_next;
      pico <= pico_next;
      cs   <= cs_next;
    end
  end

  // ----------------------------
  // Checks
  // ----------------------------
  cs_one_low_a : assert property (
    @(posedge clock) disable iff (reset) $onehot0(~cs)
  );

  ready_not_busy_a : assert property (
    @(posedge clock) disable iff (reset) (state == spi_pkg::st_ready) |-> !busy
  );

endmodule

`default_nettype wire

// File: spi_regs.sv
// ----------------------------
// SPI register file
// Decodes bus requests, holds the
// configuration and starts the
// transfer engine
// ----------------------------

`timescale 1ns/1ps
`default_nettype none

module spi_regs (
  input  logic        clock,
  input  logic        reset,

  // Bus side
  input  logic [4:0]  rw_address,
  input  logic        read_request,
  output logic [31:0] read_data,
  output logic        read_response,
  input  logic [7:0]  write_data,
  input  logic [3:0]  write_strobe,
  input  logic        write_request,
  output logic        write_response,

  // Engine side
  input  logic        busy,
  input  logic [7:0]  rx_data,
  output logic        cpol,
  output logic        cpha,
  output logic [7:0]  chip_select,
  output logic [7:0]  clock_div,
  output logic [7:0]  tx_data,
  output logic        tx_start
);

  logic valid_write;
  logic wdata_accept;

  // Partial strobes are acknowledged but ignored
  assign valid_write = write_request && (&write_strobe);

  // A pending start counts as busy, since the engine state lags by a cycle
  assign wdata_accept = valid_write && (rw_address == spi_pkg::reg_wdata) &&
                        !busy && !tx_start;

  // ----------------------------
  // Responses
  // ----------------------------
  always_ff @(posedge clock) begin
    if (reset) begin
      read_response  <= 1'b0;
      write_response <= 1'b0;
    end else begin
      read_response  <= read_request;
      write_response <= write_request;
    end
  end

  // Read data, valid only alongside read_response
  always_ff @(posedge clock) begin
    if (reset) begin
      read_data <= spi_pkg::read_default;
    end else if (read_request) begin
      case (rw_address)
        spi_pkg::reg_cpol:        read_data <= {31'd0, cpol};
        spi_pkg::reg_cpha:        read_data <= {31'd0, cpha};
        spi_pkg::reg_chip_select: read_data <= {24'd0, chip_select};
        spi_pkg::reg_clock_conf:  read_data <= {24'd0, clock_div};
        spi_pkg::reg_rdata:       read_data <= {24'd0, rx_data};
        spi_pkg::reg_busy:        read_data <= {31'd0, busy};
        default:                  read_data <= spi_pkg::read_default;
      endcase
    end else begin
      read_data <= spi_pkg::read_default;
    end
  end

  // ----------------------------
  // Configuration
  // ----------------------------
  always_ff @(posedge clock) begin
    if (reset) begin
      cpol        <= 1'b0;
      cpha        <= 1'b0;
      chip_select <= spi_pkg::cs_none;
      clock_div   <= 8'h00;
    end else if (valid_write) begin
      case (rw_address)
        spi_pkg::reg_cpol:        cpol        <= write_data[0];
        spi_pkg::reg_cpha:        cpha        <= write_data[0];
        spi_pkg::reg_chip_select: chip_select <= write_data;
        spi_pkg::reg_clock_conf:  clock_div   <= write_data;
        default: ;
      endcase
    end
  end

  // Transmit byte and start pulse
  always_ff @(posedge clock) begin
    if (reset) begin
      tx_start <= 1'b0;
    end else begin
      tx_start <= wdata_accept;
    end
  end

  always_ff @(posedge clock) begin
    if (wdata_accept) begin
      tx_data <= write_data;
    end
  end

  // ----------------------------
  // Checks
  // ----------------------------
  tx_start_not_busy_a : assert property (
    @(posedge clock) disable iff (reset) tx_start |-> !busy
  );

  read_response_timing_a : assert property (
    @(posedge clock) disable iff (reset) read_request |=> read_response
  );

endmodule

`default_nettype wire

// File: spi_pkg.sv
// ----------------------------
// SPI controller package
// Register map, engine state
// encoding and reset constants
// ----------------------------

`default_nettype none

package spi_pkg;

  // ----------------------------
  // Register offsets
  // ----------------------------
  localparam logic [4:0] reg_cpol        = 5'h00;
  localparam logic [4:0] reg_cpha        = 5'h04;
  localparam logic [4:0] reg_chip_select = 5'h08;
  localparam logic [4:0] reg_clock_conf  = 5'h0c;
  localparam logic [4:0] reg_wdata       = 5'h10;
  localparam logic [4:0] reg_rdata       = 5'h14;
  localparam logic [4:0] reg_busy        = 5'h18;

  // ----------------------------
  // Engine states, one-hot
  // ----------------------------
  typedef enum logic [3:0] {
    st_ready   = 4'b0001,
    st_idle    = 4'b0010,
    st_phase_a = 4'b0100,
    st_phase_n = 4'b1000
  } spi_state_t;

  // No device selected
  localparam logic [7:0] cs_none = 8'hff;

  // Unmapped address or no read pending
  localparam logic [31:0] read_default = 32'hdeadbeef;

endpackage

`default_nettype wire
